/* hdl/fetch_config.svh */
/*
 * Fetch front end configuration macros
 * Word width, reset PC, request cap, buffer depth
 */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

`define FETCH_XLEN             32           // Memory word width
`define FETCH_PC_RESET         32'h8000_0000 // First fetch address
`define FETCH_MAX_OUTSTANDING  1            // Cap on requests in flight (1 or 2)
`define FETCH_BUF_HALFWORDS    4            // Halfword buffer capacity

`endif

/* hdl/fetch_bus_pkg.sv */
/*
 * Instruction memory bus types
 * Bus word, byte address, halfword buffer fill command
 */
`include "fetch_config.svh"

package fetch_bus_pkg;

    typedef logic [`FETCH_XLEN-1:0] bus_word_t;  // Read data word
    typedef logic [`FETCH_XLEN-1:0] bus_addr_t;  // Byte address

    // One accepted response on its way into the buffer
    typedef struct packed {
        bus_word_t word;        // Raw response data
        logic      error;       // Bus error on this response
        logic      upper_only;  // Keep bits 31:16 only
    } fill_cmd_t;

endpackage

/* hdl/instr_pkg.sv */
/*
 * Instruction types
 * Halfword, error tagged halfword, length enum
 */
package instr_pkg;

    typedef logic [15:0] halfword_t;

    // Halfword as held in the fetch buffer
    typedef struct packed {
        logic      error;  // Came from a faulting response
        halfword_t half;
    } tagged_half_t;

    // RVC length rule
    // Bits 1:0 == 2'b11 marks a 32-bit instruction
    // Anything else is compressed
    typedef enum logic {
        LEN_16 = 1'b0,
        LEN_32 = 1'b1
    } instr_len_e;

endpackage

/* hdl/fetch_ifs.sv */
/*
 * Internal fetch interfaces
 * fetch_fill_if carries requester loads and flush to the buffer
 * fetch_view_if carries the buffer head view and consume pulses
 */
`timescale 1ns/1ps
`include "fetch_config.svh"

interface fetch_fill_if;
    logic                    fill_valid;  // Write fill this cycle
    fetch_bus_pkg::fill_cmd_t fill;
    logic                    flush;       // Empty the buffer
    logic                    room;        // At most two halfwords held

    modport requester (output fill_valid, output fill, output flush, input room);
    modport buffer    (input fill_valid, input fill, input flush, output room);
endinterface

interface fetch_view_if;
    instr_pkg::tagged_half_t                    head0;  // Oldest halfword
    instr_pkg::tagged_half_t                    head1;  // Next oldest
    logic [$clog2(`FETCH_BUF_HALFWORDS+1)-1:0]  depth;  // Halfwords held
    logic                                       take2;  // Drop 2 bytes
    logic                                       take4;  // Drop 4 bytes

    modport buffer (output head0, output head1, output depth, input take2, input take4);
    modport issue  (input head0, input head1, input depth, output take2, output take4);
endinterface

/* hdl/fetch_requester.sv */
/*
 * Fetch request side
 * Fetch address, request level, outstanding and ignore counters,
 * misalignment flag, response qualification, flush on redirect
 */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_requester (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    cf_req,           // Control flow change
    input  fetch_bus_pkg::bus_addr_t cf_target,
    output logic                    cf_ack,
    output logic                    imem_req,
    output fetch_bus_pkg::bus_addr_t imem_addr,
    input  logic                    imem_gnt,
    output logic                    imem_ack,
    input  logic                    imem_recv,
    input  logic                    imem_error,
    input  fetch_bus_pkg::bus_word_t imem_rdata,
    input  logic                    lone_upper_half,  // Half a 32-bit instr waiting
    fetch_fill_if.requester         fill
);

    localparam int CNT_W = $clog2(`FETCH_MAX_OUTSTANDING + 1) + 1;

    logic [CNT_W-1:0] reqs_outstanding;   // Granted, not yet answered
    logic [CNT_W-1:0] n_reqs_outstanding;
    logic [CNT_W-1:0] ignore_rsps;        // Stale responses still to come
    logic             fetch_misaligned;   // Next fill keeps upper half only
    logic             cf_change;
    logic             req_taken;
    logic             rsp_recv;
    logic             drop_response;
    logic             allow_new_req;
    logic             n_imem_req;

    // ----------------------------------------
    // Handshake qualifiers
    // ----------------------------------------
    assign cf_ack        = !imem_req || imem_gnt;   // Nothing left hanging on the bus
    assign cf_change     = cf_req && cf_ack;
    assign req_taken     = imem_req && imem_gnt;
    assign imem_ack      = fill.room;
    assign rsp_recv      = imem_recv && imem_ack;
    assign drop_response = |ignore_rsps;

    assign n_reqs_outstanding = reqs_outstanding + CNT_W'(req_taken) - CNT_W'(rsp_recv);

    // Count the request just granted so the cap is never passed
    assign allow_new_req = n_reqs_outstanding < CNT_W'(`FETCH_MAX_OUTSTANDING);
    assign n_imem_req    = ((fill.room || cf_change || lone_upper_half) && allow_new_req) ||
                           (imem_req && !imem_gnt);  // Hold until granted

    // ----------------------------------------
    // Request state
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req         <= 1'b0;
            imem_addr        <= `FETCH_PC_RESET;
            reqs_outstanding <= '0;
        end else begin
            imem_req         <= n_imem_req;
            reqs_outstanding <= n_reqs_outstanding;
            if (cf_change) begin
                imem_addr <= {cf_target[31:2], 2'b00};  // Word of the target
            end else if (req_taken) begin
                imem_addr <= imem_addr + 32'd4;
            end
        end
    end

    // Drop everything in flight at a redirect
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ignore_rsps <= '0;
        end else if (cf_change) begin
            ignore_rsps <= n_reqs_outstanding;
        end else if (rsp_recv && drop_response) begin
            ignore_rsps <= ignore_rsps - CNT_W'(1);
        end
    end

    // Set by a halfword aligned target until the first kept fill
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            fetch_misaligned <= 1'b0;
        end else if (cf_change) begin
            fetch_misaligned <= cf_target[1];
        end else if (fill.fill_valid) begin
            fetch_misaligned <= 1'b0;
        end
    end

    // ----------------------------------------
    // Fill commands toward the buffer
    // ----------------------------------------
    assign fill.fill_valid      = rsp_recv && !drop_response;
    assign fill.fill.word       = imem_rdata;
    assign fill.fill.error      = imem_error;
    assign fill.fill.upper_only = fetch_misaligned;
    assign fill.flush           = cf_change;  // Buffer empties on this edge

endmodule

/* hdl/fetch_buffer.sv */
/*
 * Halfword fetch buffer
 * Shifting queue of error tagged halfwords that loads a word or its
 * upper half and consumes two or four bytes in the same cycle
 */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_buffer (
    input  logic         g_clk,
    input  logic         g_resetn,
    fetch_fill_if.buffer fill,
    fetch_view_if.buffer view
);

    localparam int NUM_H   = `FETCH_BUF_HALFWORDS;
    localparam int DEPTH_W = $clog2(NUM_H + 1);

    instr_pkg::tagged_half_t q     [NUM_H];  // Slot 0 is the oldest
    instr_pkg::tagged_half_t q_nxt [NUM_H];
    instr_pkg::tagged_half_t ld    [2];      // Halfwords of this fill, in order
    logic [DEPTH_W-1:0]      depth;
    logic [DEPTH_W-1:0]      depth_nxt;

    // ----------------------------------------
    // Incoming halfwords
    // ----------------------------------------
    always_comb begin
        ld[0].error = fill.fill.error;     // Same error on both halves
        ld[1].error = fill.fill.error;
        ld[1].half  = fill.fill.word[31:16];
        if (fill.fill.upper_only) begin
            ld[0].half = fill.fill.word[31:16];
        end else begin
            ld[0].half = fill.fill.word[15:0];
        end
    end

    // ----------------------------------------
    // Shift out taken halves, append loads
    // ----------------------------------------
    always_comb begin
        int unsigned n_take;
        int unsigned n_load;
        int unsigned base;
        n_take = view.take4 ? 2 : (view.take2 ? 1 : 0);
        if (!fill.fill_valid) begin
            n_load = 0;
        end else if (fill.fill.upper_only) begin
            n_load = 1;
        end else begin
            n_load = 2;
        end
        base = int'(depth) - n_take;  // Survivors after the take
        for (int i = 0; i < NUM_H; i++) begin
            if (i < base) begin
                q_nxt[i] = q[i + n_take];
            end else if (i - base < n_load) begin
                q_nxt[i] = ld[i - base];
            end else begin
                q_nxt[i] = q[i];          // Slot unused
            end
        end
        depth_nxt = DEPTH_W'(base + n_load);
    end

    always_ff @(posedge g_clk) begin
        q <= q_nxt;  // Halfword slots
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth <= '0;
        end else if (fill.flush) begin
            depth <= '0;     // Flush beats loads and takes
        end else begin
            depth <= depth_nxt;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign fill.room  = depth <= DEPTH_W'(NUM_H - 2);  // A whole word still fits
    assign view.head0 = q[0];
    assign view.head1 = q[1];
    assign view.depth = depth;

endmodule

/* hdl/fetch_issue.sv */
/*
 * Fetch issue side
 * Length decode, decode-stage valid/data/error, consume pulses
 */
`timescale 1ns/1ps

module fetch_issue (
    fetch_view_if.issue              view,
    input  logic                     s1_busy,          // Decode stalled
    output logic                     s1_valid,
    output fetch_bus_pkg::bus_word_t s1_data,
    output logic                     s1_error,
    output logic                     lone_upper_half   // Need the other half
);

    instr_pkg::instr_len_e len;
    logic                  accept;

    // Both low bits set means a full 32-bit encoding
    assign len = (view.head0.half[1:0] == 2'b11) ? instr_pkg::LEN_32 : instr_pkg::LEN_16;

    // ----------------------------------------
    // Decode stage outputs
    // ----------------------------------------
    always_comb begin
        if (len == instr_pkg::LEN_32) begin
            s1_valid = view.depth >= 2;
            s1_data  = {view.head1.half, view.head0.half};
            s1_error = view.head0.error || view.head1.error;
        end else begin
            s1_valid = view.depth >= 1;
            s1_data  = {16'h0000, view.head0.half};  // Zero extend
            s1_error = view.head0.error;
        end
    end

    assign accept     = s1_valid && !s1_busy;
    assign view.take2 = accept && (len == instr_pkg::LEN_16);
    assign view.take4 = accept && (len == instr_pkg::LEN_32);

    // First half of a 32-bit instr alone in the buffer
    assign lone_upper_half = (len == instr_pkg::LEN_32) && (view.depth == 1);

endmodule

/* hdl/fetch_top.sv */
/*
 * Instruction fetch front end top level
 * Requester, halfword buffer and issue block
 */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    // Control flow change
    input  logic                   cf_req,
    input  logic [`FETCH_XLEN-1:0] cf_target,
    output logic                   cf_ack,
    // Instruction memory
    output logic                   imem_req,
    output logic [`FETCH_XLEN-1:0] imem_addr,
    input  logic                   imem_gnt,
    output logic                   imem_ack,
    input  logic                   imem_recv,
    input  logic                   imem_error,
    input  logic [`FETCH_XLEN-1:0] imem_rdata,
    // Decode stage
    input  logic                   s1_busy,
    output logic                   s1_valid,
    output logic [`FETCH_XLEN-1:0] s1_data,
    output logic                   s1_error
);

    logic lone_upper_half;  // Issue asks for the rest of a 32-bit instr

    fetch_fill_if i_fill_if ();
    fetch_view_if i_view_if ();

    // ----------------------------------------
    // Request side
    // ----------------------------------------
    fetch_requester i_requester (
        .g_clk           (g_clk),
        .g_resetn        (g_resetn),
        .cf_req          (cf_req),
        .cf_target       (cf_target),
        .cf_ack          (cf_ack),
        .imem_req        (imem_req),
        .imem_addr       (imem_addr),
        .imem_gnt        (imem_gnt),
        .imem_ack        (imem_ack),
        .imem_recv       (imem_recv),
        .imem_error      (imem_error),
        .imem_rdata      (imem_rdata),
        .lone_upper_half (lone_upper_half),
        .fill            (i_fill_if.requester)
    );

    fetch_buffer i_buffer (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .fill     (i_fill_if.buffer),
        .view     (i_view_if.buffer)
    );

    // Combinational to decode
    fetch_issue i_issue (
        .view            (i_view_if.issue),
        .s1_busy         (s1_busy),
        .s1_valid        (s1_valid),
        .s1_data         (s1_data),
        .s1_error        (s1_error),
        .lone_upper_half (lone_upper_half)
    );

endmodule

/* tests/fetch_checker.sv */
/*
 * Instruction stream checker
 * Tracks the expected PC and compares each accepted instruction
 */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_checker (
    input logic        g_clk,
    input logic        g_resetn,
    input logic        cf_req,
    input logic [31:0] cf_target,
    input logic        cf_ack,
    input logic        imem_req,
    input logic [31:0] imem_addr,
    input logic        s1_valid,
    input logic        s1_busy,
    input logic [31:0] s1_data,
    input logic        s1_error
);

    logic [31:0] exp_pc;
    logic        in_reset     = 1'b0;  // Reset seen on the last edge
    int unsigned data_errors  = 0;
    int unsigned flag_errors  = 0;
    int unsigned reset_errors = 0;
    int unsigned issued       = 0;   // Accepted instructions

    // Halfword of the memory image at a byte address
    function automatic logic [15:0] half_at(input logic [31:0] addr);
        logic [31:0] w;
        w = fetch_tb.image_word({addr[31:2], 2'b00});
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    // First cycle after release still shows the reset state
    always @(posedge g_clk) begin
        if (g_resetn && in_reset) begin
            if (imem_req !== 1'b0 || imem_addr !== `FETCH_PC_RESET ||
                cf_ack !== 1'b1 || s1_valid !== 1'b0) begin
                reset_errors++;
                $display("CHECK FAILED at %0t: after reset req %b addr %h ack %b valid %b",
                         $time, imem_req, imem_addr, cf_ack, s1_valid);
            end
        end
        in_reset <= !g_resetn;
    end

    always @(posedge g_clk) begin
        logic [15:0] lo;
        logic [15:0] hi;
        logic        wide;
        logic [31:0] exp_data;
        logic        exp_err;
        logic [31:0] next_pc;
        next_pc = exp_pc;
        if (!g_resetn) begin
            next_pc = `FETCH_PC_RESET;
        end else begin
            // Accept first since it still belongs to the old stream
            if (s1_valid && !s1_busy) begin
                lo       = half_at(exp_pc);
                hi       = half_at(exp_pc + 32'd2);
                wide     = (lo[1:0] == 2'b11);       // 32-bit encoding
                exp_data = wide ? {hi, lo} : {16'h0000, lo};
                exp_err  = fetch_tb.addr_faults(exp_pc) ||
                           (wide && fetch_tb.addr_faults(exp_pc + 32'd2));
                issued++;
                if (s1_data !== exp_data) begin
                    data_errors++;
                    $display("CHECK FAILED at %0t: pc %h data %h, expected %h",
                             $time, exp_pc, s1_data, exp_data);
                end
                if (s1_error !== exp_err) begin
                    flag_errors++;
                    $display("CHECK FAILED at %0t: pc %h error %b, expected %b",
                             $time, exp_pc, s1_error, exp_err);
                end
                next_pc = exp_pc + (wide ? 32'd4 : 32'd2);
            end
            if (cf_req && cf_ack) begin
                next_pc = cf_target;                 // New stream
            end
        end
        exp_pc <= next_pc;
    end

endmodule

/* tests/fetch_asserts.sv */
/*
 * Concurrent assertions for the fetch front end
 * Memory request hold, decode-side hold under busy, in-flight cap
 */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_asserts (
    input logic        g_clk,
    input logic        g_resetn,
    input logic        cf_req,
    input logic        cf_ack,
    input logic        imem_req,
    input logic [31:0] imem_addr,
    input logic        imem_gnt,
    input logic        imem_recv,
    input logic        imem_ack,
    input logic        s1_valid,
    input logic        s1_busy,
    input logic [31:0] s1_data,
    input logic        s1_error
);

    int in_flight = 0;        // Granted minus answered
    int unsigned failures = 0;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(imem_req && imem_gnt) - int'(imem_recv && imem_ack);
        end
    end

    // Request and address wait for the grant
    req_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        imem_req && !imem_gnt |=> imem_req && $stable(imem_addr))
        else begin
            failures++;
            $error("imem_req dropped or imem_addr moved before grant");
        end

    // Stalled instruction holds unless a redirect flushes it
    issue_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_valid && s1_busy && !(cf_req && cf_ack)
        |=> s1_valid && $stable(s1_data) && $stable(s1_error))
        else begin
            failures++;
            $error("s1 instruction changed while decode was busy");
        end

    in_flight_cap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        in_flight <= `FETCH_MAX_OUTSTANDING)
        else begin
            failures++;
            $error("more requests in flight than allowed");
        end

endmodule

bind fetch_top fetch_asserts i_asserts (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .cf_req    (cf_req),
    .cf_ack    (cf_ack),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_gnt  (imem_gnt),
    .imem_recv (imem_recv),
    .imem_ack  (imem_ack),
    .s1_valid  (s1_valid),
    .s1_busy   (s1_busy),
    .s1_data   (s1_data),
    .s1_error  (s1_error)
);

/* tests/fetch_tb.sv */
/*
 * Fetch front end testbench
 * Clock, reset, memory model, stimulus table, watchdog, final report
 */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;

    logic        g_clk;
    logic        g_resetn;
    logic        cf_req;
    logic [31:0] cf_target;
    logic        cf_ack;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_gnt;
    logic        imem_ack;
    logic        imem_recv;
    logic        imem_error;
    logic [31:0] imem_rdata;
    logic        s1_busy;
    logic        s1_valid;
    logic [31:0] s1_data;
    logic        s1_error;

    // One row of stimulus
    typedef struct packed {
        logic        redirect;  // Apply target first
        logic [31:0] target;
        logic [7:0]  busy_pct;  // Chance of s1_busy
        logic [7:0]  gnt_pct;   // Chance of imem_gnt
        logic [15:0] cycles;    // Run length
    } step_t;

    localparam int NUM_STEPS = 9;

    step_t steps [NUM_STEPS] = '{
        '{1'b0, 32'h0000_0000,  0, 100, 120},  // Straight run from reset
        '{1'b0, 32'h0000_0000, 40,  60, 150},  // Random back-pressure
        '{1'b1, 32'h8000_0100,  0, 100, 100},  // Word aligned jump
        '{1'b1, 32'h8000_0206, 30,  70, 120},  // Halfword aligned jump
        '{1'b1, 32'h8000_0300, 20,  80, 120},  // Into the error window
        '{1'b1, 32'h8000_031a, 50,  50, 150},  // Straddles window end
        '{1'b1, 32'h8000_0042,  0, 100,  10},
        '{1'b1, 32'h8000_0080, 10,  90,  10},  // Redirect close behind
        '{1'b1, 32'h8000_0012, 25,  40, 150}
    };

    int          seed = 32'hc97f_d911;
    int          busy_pct;
    int          gnt_pct;
    int unsigned tb_errors = 0;

    // ----------------------------------------
    // Memory image
    // ----------------------------------------
    function automatic logic [31:0] image_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return ((a >> 2) * 32'h9e37_79b9) ^ (a << 7);  // Mixes both encodings
    endfunction

    // Bus error on one 32-byte window
    function automatic logic addr_faults(input logic [31:0] addr);
        return (addr & 32'hffff_ffe0) == 32'h8000_0300;
    endfunction

    function automatic logic chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    fetch_top i_fetch_top (.*);

    fetch_checker i_checker (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_req    (cf_req),
        .cf_target (cf_target),
        .cf_ack    (cf_ack),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .s1_valid  (s1_valid),
        .s1_busy   (s1_busy),
        .s1_data   (s1_data),
        .s1_error  (s1_error)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    // ----------------------------------------
    // Memory model answering in order two cycles after grant
    // ----------------------------------------
    logic [31:0] addr_q [$];
    int unsigned due_q  [$];
    int unsigned cyc;
    logic        presenting;   // Response on the bus until acked

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            addr_q.delete();
            due_q.delete();
            presenting = 1'b0;
            cyc        = 0;
        end else begin
            cyc++;
            if (imem_recv && imem_ack) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
                presenting = 1'b0;
            end
            if (imem_req && imem_gnt) begin
                addr_q.push_back(imem_addr);
                due_q.push_back(cyc + 2);
            end
        end
    end

    always @(negedge g_clk) begin
        if (!g_resetn) begin
            imem_gnt  = 1'b0;
            imem_recv = 1'b0;
            s1_busy   = 1'b0;
        end else begin
            s1_busy  = chance(busy_pct);
            imem_gnt = chance(gnt_pct);
            if (!presenting && addr_q.size() > 0 && cyc >= due_q[0] && chance(70)) begin
                presenting = 1'b1;
            end
            imem_recv  = presenting;
            imem_rdata = presenting ? image_word(addr_q[0]) : 32'h0;
            imem_error = presenting && addr_faults(addr_q[0]);
        end
    end

    // Hold cf_req until the change cycle
    task automatic redirect(input logic [31:0] target);
        logic        accepted;
        int unsigned waited;
        accepted  = 1'b0;
        waited    = 0;
        cf_req    = 1'b1;
        cf_target = target;
        while (!accepted && waited < 50) begin
            @(posedge g_clk);
            accepted = cf_ack;
            waited++;
            @(negedge g_clk);
        end
        cf_req = 1'b0;
        if (!accepted) begin
            tb_errors++;
            $display("Redirect to %h was never acknowledged", target);
        end
    endtask

    // ----------------------------------------
    // Stimulus and report
    // ----------------------------------------
    initial begin
        int unsigned total;
        g_resetn   = 1'b0;
        cf_req     = 1'b0;
        cf_target  = 32'h0;
        s1_busy    = 1'b0;
        imem_gnt   = 1'b0;
        imem_recv  = 1'b0;
        imem_error = 1'b0;
        imem_rdata = 32'h0;
        busy_pct   = 0;
        gnt_pct    = 100;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            busy_pct = int'(steps[i].busy_pct);
            gnt_pct  = int'(steps[i].gnt_pct);
            if (steps[i].redirect) begin
                redirect(steps[i].target);
            end
            repeat (int'(steps[i].cycles)) @(negedge g_clk);
        end
        if (i_checker.issued == 0) begin
            tb_errors++;
            $display("No instruction was ever issued to decode");
        end
        total = i_checker.data_errors + i_checker.flag_errors + i_checker.reset_errors +
                i_fetch_top.i_asserts.failures + tb_errors;
        $display("Errors: data %0d, flag %0d, reset %0d, assertion %0d, other %0d in %0d issued",
                 i_checker.data_errors, i_checker.flag_errors, i_checker.reset_errors,
                 i_fetch_top.i_asserts.failures, tb_errors, i_checker.issued);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Three times the planned run including reset
    initial begin
        int unsigned limit;
        limit = 8;
        foreach (steps[i]) limit += int'(steps[i].cycles);
        #(limit * 4 * 3);
        $display("Timeout: the run did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/fetch_bus_pkg.sv
hdl/instr_pkg.sv
hdl/fetch_ifs.sv
hdl/fetch_requester.sv
hdl/fetch_buffer.sv
hdl/fetch_issue.sv
hdl/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_asserts.sv
tests/fetch_tb.sv

/* Makefile */
# Verilator build for the fetch front end testbench

TOP = fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
